//--- source/cachePkg.sv
package cachePkg;

    // cache geometry
    localparam int wayCount = 4;
    localparam int setCount = 16;
    localparam int offsetWidth = 4;
    localparam int setWidth = 4;
    // tag is address bits 31 down to 8
    localparam int tagWidth = 24;
    localparam int lineWidth = 128;
    localparam int busWidth = 64;

    typedef logic [tagWidth-1:0] cacheTag;
    typedef logic [setWidth-1:0] setIndex;
    typedef logic [1:0] wayIndex;
    typedef logic [lineWidth-1:0] lineData;
    typedef logic [7:0] byteMask;
    // upper word always zero
    typedef logic [63:0] busAddress;

    typedef enum logic [2:0] {
        idle,
        lookup,
        miss,
        replace,
        wresp,
        refill
    } cacheState;

    // two beats of 8 bytes, incrementing
    localparam logic [7:0] burstLen = 8'd1;
    localparam logic [2:0] burstSize = 3'd3;
    localparam logic [1:0] burstIncr = 2'b01;

endpackage

//--- source/tagStore.sv
module tagStore (
    input  logic              clock,
    input  logic              reset,
    input  cachePkg::setIndex setSel,
    input  cachePkg::cacheTag lookupTag,
    input  cachePkg::wayIndex accessWay,
    input  logic              tagWrite,
    input  logic              validWrite,
    input  logic              dirtyWrite,
    input  logic              dirtyValue,
    output logic              hit,
    output cachePkg::wayIndex hitWay,
    output logic              victimDirty,
    output cachePkg::cacheTag victimTag
);

    // tag, valid and dirty per set and way
    cachePkg::cacheTag tagArray [cachePkg::setCount][cachePkg::wayCount];
    logic [cachePkg::wayCount-1:0] validBits [cachePkg::setCount];
    logic [cachePkg::wayCount-1:0] dirtyBits [cachePkg::setCount];

    // per-way match of the addressed set
    logic [cachePkg::wayCount-1:0] wayMatch;

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int s = 0; s < cachePkg::setCount; s++) begin
                validBits[s] <= '0;
                dirtyBits[s] <= '0;
                for (int w = 0; w < cachePkg::wayCount; w++) begin
                    tagArray[s][w] <= '0;
                end
            end
        end else begin
            // tag lands on the first refill beat
            if (tagWrite) begin
                tagArray[setSel][accessWay] <= lookupTag;
            end
            // valid only ever gets set, on the last refill beat
            if (validWrite) begin
                validBits[setSel][accessWay] <= 1'b1;
            end
            // set by write hit, cleared after writeback or refill
            if (dirtyWrite) begin
                dirtyBits[setSel][accessWay] <= dirtyValue;
            end
        end
    end

    // compare all four ways at once
    always_comb begin
        for (int w = 0; w < cachePkg::wayCount; w++) begin
            wayMatch[w] = validBits[setSel][w] && (tagArray[setSel][w] == lookupTag);
        end
    end

    assign hit = |wayMatch;

    // priority encode, highest way wins
    always_comb begin
        hitWay = '0;
        for (int w = 0; w < cachePkg::wayCount; w++) begin
            if (wayMatch[w]) begin
                hitWay = cachePkg::wayIndex'(w);
            end
        end
    end

    // chosen way needs writeback only if valid and dirty
    assign victimDirty = validBits[setSel][accessWay] && dirtyBits[setSel][accessWay];
    assign victimTag = tagArray[setSel][accessWay];

endmodule

//--- source/lineData.sv
module lineData (
    input  logic              clock,
    input  logic [5:0]        lineSel,
    input  logic              hitWrite,
    input  logic              refillWrite,
    input  logic [3:0]        offset,
    input  logic [63:0]       storeData,
    input  cachePkg::byteMask storeMask,
    input  logic [63:0]       refillBeat,
    input  logic              refillHigh,
    output cachePkg::lineData readLine,
    output logic [63:0]       loadData
);

    // 16 sets times 4 ways, indexed by {set, way}
    cachePkg::lineData lines [64];

    // byte offset in bits
    logic [6:0] bitShift;
    logic [63:0] storeBits;
    cachePkg::lineData writeData;
    cachePkg::lineData writeMask;
    cachePkg::lineData shiftedLine;

    assign bitShift = {offset, 3'b000};

    // byte mask widened to a bit mask
    always_comb begin
        for (int b = 0; b < 8; b++) begin
            storeBits[b*8 +: 8] = {8{storeMask[b]}};
        end
    end

    // hit store moves to its offset, refill fills one half
    always_comb begin
        if (hitWrite) begin
            writeData = {64'd0, storeData} << bitShift;
            writeMask = {64'd0, storeBits} << bitShift;
        end else if (refillHigh) begin
            writeData = {refillBeat, 64'd0};
            writeMask = {{64{1'b1}}, 64'd0};
        end else begin
            writeData = {64'd0, refillBeat};
            writeMask = {64'd0, {64{1'b1}}};
        end
    end

    always_ff @(posedge clock) begin
        if (hitWrite || refillWrite) begin
            lines[lineSel] <= (lines[lineSel] & ~writeMask) | (writeData & writeMask);
        end
        // registered read, old contents on a same-cycle write
        readLine <= lines[lineSel];
    end

    // load data starts at the byte offset
    assign shiftedLine = readLine >> bitShift;
    assign loadData = shiftedLine[63:0];

endmodule

//--- source/cacheController.sv
module cacheController #(
    parameter logic [15:0] lfsrSeed = 16'd1
) (
    input  logic                clock,
    input  logic                reset,
    input  logic                cacheValid,
    input  logic                cacheOp,
    input  logic                hit,
    input  logic                victimDirty,
    input  cachePkg::cacheTag   victimTag,
    input  cachePkg::setIndex   setSel,
    input  cachePkg::cacheTag   reqTag,
    input  cachePkg::wayIndex   hitWay,
    input  cachePkg::lineData   readLine,
    output logic                cacheDataOk,
    output cachePkg::wayIndex   accessWay,
    output logic                tagWrite,
    output logic                validWrite,
    output logic                dirtyWrite,
    output logic                dirtyValue,
    output logic                hitWrite,
    output logic                refillWrite,
    output logic                refillHigh,
    input  logic                arReady,
    output logic                arValid,
    output cachePkg::busAddress arAddr,
    input  logic                rValid,
    input  logic                rLast,
    output logic                rReady,
    input  logic                awReady,
    output logic                awValid,
    output cachePkg::busAddress awAddr,
    input  logic                wReady,
    output logic                wValid,
    output logic                wLast,
    output logic [63:0]         wData,
    input  logic                bValid,
    output logic                bReady
);

    cachePkg::cacheState state;
    cachePkg::cacheState nextState;
    logic [15:0] lfsr;
    cachePkg::wayIndex victimWay;
    // 0 for the first beat of a burst, 1 for the second
    logic beatIndex;

    logic lookupHit;
    logic wFire;
    logic rFire;

    assign lookupHit = (state == cachePkg::lookup) && hit;
    assign wFire = wValid && wReady;
    assign rFire = rValid && rReady;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= cachePkg::idle;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        unique case (state)
            cachePkg::idle: begin
                if (cacheValid) begin
                    nextState = cachePkg::lookup;
                end
            end
            cachePkg::lookup: begin
                nextState = hit ? cachePkg::idle : cachePkg::miss;
            end
            cachePkg::miss: begin
                // dirty victim goes out first, clean one is just replaced
                if (awValid && awReady) begin
                    nextState = cachePkg::replace;
                end else if (arValid && arReady) begin
                    nextState = cachePkg::refill;
                end
            end
            cachePkg::replace: begin
                if (wFire && wLast) begin
                    nextState = cachePkg::wresp;
                end
            end
            cachePkg::wresp: begin
                // victim now clean, back to miss for the read
                if (bValid && bReady) begin
                    nextState = cachePkg::miss;
                end
            end
            cachePkg::refill: begin
                if (rFire && rLast) begin
                    nextState = cachePkg::lookup;
                end
            end
            default: begin
                nextState = cachePkg::idle;
            end
        endcase
    end

    // free-running victim source
    always_ff @(posedge clock) begin
        if (reset) begin
            lfsr <= lfsrSeed;
        end else begin
            lfsr <= {lfsr[0] ^ lfsr[2] ^ lfsr[3] ^ lfsr[5], lfsr[15:1]};
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            victimWay <= '0;
            beatIndex <= 1'b0;
            cacheDataOk <= 1'b0;
        end else begin
            // victim picked as the miss is seen
            if ((state == cachePkg::lookup) && !hit) begin
                victimWay <= lfsr[1:0];
            end
            if (wFire) begin
                beatIndex <= !wLast;
            end else if (rFire) begin
                beatIndex <= !rLast;
            end
            // data is out of the registered read one cycle later
            cacheDataOk <= lookupHit;
        end
    end

    // hit way while looking up, saved victim otherwise
    assign accessWay = ((state == cachePkg::idle) || (state == cachePkg::lookup))
                       ? hitWay : victimWay;

    // tag store and data array controls
    assign hitWrite = lookupHit && cacheOp;
    assign refillWrite = (state == cachePkg::refill) && rFire;
    assign refillHigh = beatIndex;
    assign tagWrite = refillWrite && !beatIndex;
    assign validWrite = refillWrite && rLast;
    assign dirtyWrite = hitWrite || (wFire && wLast) || validWrite;
    // only a store sets dirty
    assign dirtyValue = (state == cachePkg::lookup);

    // read and write address channels
    assign awValid = (state == cachePkg::miss) && victimDirty;
    assign arValid = (state == cachePkg::miss) && !victimDirty;
    assign awAddr = {32'd0, victimTag, setSel, 4'd0};
    assign arAddr = {32'd0, reqTag, setSel, 4'd0};

    // writeback beats, low doubleword first
    assign wValid = (state == cachePkg::replace);
    assign wLast = wValid && beatIndex;
    assign wData = beatIndex ? readLine[127:64] : readLine[63:0];

    assign bReady = (state == cachePkg::wresp);
    assign rReady = (state == cachePkg::refill);

endmodule

//--- source/dataCache.sv
module dataCache (
    input  logic                clock,
    input  logic                reset,
    // load/store unit side
    input  logic                cacheValid,
    input  logic                cacheOp,
    input  logic [63:0]         cacheAddr,
    input  logic [63:0]         cacheWdata,
    input  cachePkg::byteMask   cacheWmask,
    output logic [63:0]         cacheData,
    output logic                cacheDataOk,
    // memory side, AXI read channels
    input  logic                arReady,
    output logic                arValid,
    output cachePkg::busAddress arAddr,
    output logic [7:0]          arLen,
    output logic [2:0]          arSize,
    output logic [1:0]          arBurst,
    input  logic                rValid,
    input  logic                rLast,
    input  logic [63:0]         rData,
    output logic                rReady,
    // AXI write channels
    input  logic                awReady,
    output logic                awValid,
    output cachePkg::busAddress awAddr,
    output logic [7:0]          awLen,
    output logic [2:0]          awSize,
    output logic [1:0]          awBurst,
    input  logic                wReady,
    output logic                wValid,
    output logic                wLast,
    output logic [63:0]         wData,
    output logic [7:0]          wStrb,
    input  logic                bValid,
    output logic                bReady
);

    parameter logic [15:0] lfsrSeed = 16'd1;

    // request address fields
    cachePkg::cacheTag reqTag;
    cachePkg::setIndex setSel;
    logic [3:0] lineOffset;

    cachePkg::wayIndex accessWay;
    cachePkg::wayIndex hitWay;
    cachePkg::cacheTag victimTag;
    cachePkg::lineData readLine;
    logic hit;
    logic victimDirty;
    logic tagWrite;
    logic validWrite;
    logic dirtyWrite;
    logic dirtyValue;
    logic hitWrite;
    logic refillWrite;
    logic refillHigh;

    assign reqTag = cacheAddr[31:8];
    assign setSel = cacheAddr[7:4];
    assign lineOffset = cacheAddr[3:0];

    // fixed two-beat bursts, full strobes on writeback
    assign arLen = cachePkg::burstLen;
    assign arSize = cachePkg::burstSize;
    assign arBurst = cachePkg::burstIncr;
    assign awLen = cachePkg::burstLen;
    assign awSize = cachePkg::burstSize;
    assign awBurst = cachePkg::burstIncr;
    assign wStrb = 8'hff;

    tagStore tags0 (
        .clock       (clock),
        .reset       (reset),
        .setSel      (setSel),
        .lookupTag   (reqTag),
        .accessWay   (accessWay),
        .tagWrite    (tagWrite),
        .validWrite  (validWrite),
        .dirtyWrite  (dirtyWrite),
        .dirtyValue  (dirtyValue),
        .hit         (hit),
        .hitWay      (hitWay),
        .victimDirty (victimDirty),
        .victimTag   (victimTag)
    );

    // line select is {set, way}
    lineData data0 (
        .clock       (clock),
        .lineSel     ({setSel, accessWay}),
        .hitWrite    (hitWrite),
        .refillWrite (refillWrite),
        .offset      (lineOffset),
        .storeData   (cacheWdata),
        .storeMask   (cacheWmask),
        .refillBeat  (rData),
        .refillHigh  (refillHigh),
        .readLine    (readLine),
        .loadData    (cacheData)
    );

    cacheController #(
        .lfsrSeed (lfsrSeed)
    ) ctrl0 (
        .clock       (clock),
        .reset       (reset),
        .cacheValid  (cacheValid),
        .cacheOp     (cacheOp),
        .hit         (hit),
        .victimDirty (victimDirty),
        .victimTag   (victimTag),
        .setSel      (setSel),
        .reqTag      (reqTag),
        .hitWay      (hitWay),
        .readLine    (readLine),
        .cacheDataOk (cacheDataOk),
        .accessWay   (accessWay),
        .tagWrite    (tagWrite),
        .validWrite  (validWrite),
        .dirtyWrite  (dirtyWrite),
        .dirtyValue  (dirtyValue),
        .hitWrite    (hitWrite),
        .refillWrite (refillWrite),
        .refillHigh  (refillHigh),
        .arReady     (arReady),
        .arValid     (arValid),
        .arAddr      (arAddr),
        .rValid      (rValid),
        .rLast       (rLast),
        .rReady      (rReady),
        .awReady     (awReady),
        .awValid     (awValid),
        .awAddr      (awAddr),
        .wReady      (wReady),
        .wValid      (wValid),
        .wLast       (wLast),
        .wData       (wData),
        .bValid      (bValid),
        .bReady      (bReady)
    );

endmodule

//--- testbench/memoryModel.sv
module memoryModel (
    input  logic                clock,
    input  logic                reset,
    input  logic                stallEnable,
    output logic                arReady,
    input  logic                arValid,
    input  cachePkg::busAddress arAddr,
    output logic                rValid,
    output logic                rLast,
    output logic [63:0]         rData,
    input  logic                rReady,
    output logic                awReady,
    input  logic                awValid,
    input  cachePkg::busAddress awAddr,
    output logic                wReady,
    input  logic                wValid,
    input  logic [63:0]         wData,
    output logic                bValid,
    input  logic                bReady
);

    // 4 KB of doublewords, filled by the testbench
    logic [63:0] mem [512];
    int readBase;
    int writeBase;

    // stall length for one channel step
    function automatic int gapLength();
        return stallEnable ? int'($urandom_range(3, 0)) : 0;
    endfunction

    // each step ends just after a rising edge
    task automatic idleCycles(input int count);
        repeat (count) begin
            @(posedge clock);
            #1;
        end
    endtask

    // read side: address, then two beats
    initial begin
        arReady = 1'b0;
        rValid = 1'b0;
        rLast = 1'b0;
        rData = '0;
        @(posedge clock);
        while (reset) @(posedge clock);
        #1;
        forever begin
            idleCycles(gapLength());
            arReady = 1'b1;
            @(posedge clock);
            while (!arValid) @(posedge clock);
            readBase = int'(arAddr[11:3]);
            #1;
            arReady = 1'b0;
            for (int b = 0; b < 2; b++) begin
                idleCycles(gapLength());
                rValid = 1'b1;
                rLast = (b == 1);
                rData = mem[readBase + b];
                @(posedge clock);
                while (!rReady) @(posedge clock);
                #1;
                rValid = 1'b0;
                rLast = 1'b0;
            end
        end
    end

    // write side: address, two beats, response
    initial begin
        awReady = 1'b0;
        wReady = 1'b0;
        bValid = 1'b0;
        @(posedge clock);
        while (reset) @(posedge clock);
        #1;
        forever begin
            idleCycles(gapLength());
            awReady = 1'b1;
            @(posedge clock);
            while (!awValid) @(posedge clock);
            writeBase = int'(awAddr[11:3]);
            #1;
            awReady = 1'b0;
            // low doubleword arrives first
            for (int b = 0; b < 2; b++) begin
                idleCycles(gapLength());
                wReady = 1'b1;
                @(posedge clock);
                while (!wValid) @(posedge clock);
                mem[writeBase + b] = wData;
                #1;
                wReady = 1'b0;
            end
            idleCycles(gapLength());
            bValid = 1'b1;
            @(posedge clock);
            while (!bReady) @(posedge clock);
            #1;
            bValid = 1'b0;
        end
    end

endmodule

//--- testbench/dataCache_props.sv
module dataCacheProps (
    input logic                clock,
    input logic                reset,
    input logic                cacheDataOk,
    input logic                arValid,
    input logic                arReady,
    input cachePkg::busAddress arAddr,
    input logic                awValid,
    input logic                awReady,
    input cachePkg::busAddress awAddr
);

    // failure count, read back at the end of the run
    int assertFailures = 0;

    // address requests stay up and stable until taken
    arHold: assert property (@(posedge clock) disable iff (reset)
        arValid && !arReady |=> arValid && $stable(arAddr))
    else begin
        assertFailures++;
        $error("read address request dropped or changed before arReady");
    end

    awHold: assert property (@(posedge clock) disable iff (reset)
        awValid && !awReady |=> awValid && $stable(awAddr))
    else begin
        assertFailures++;
        $error("write address request dropped or changed before awReady");
    end

    // one cycle per completed access
    okPulse: assert property (@(posedge clock) disable iff (reset)
        cacheDataOk |=> !cacheDataOk)
    else begin
        assertFailures++;
        $error("cacheDataOk held longer than one cycle");
    end

    // read and write address never requested together
    oneAddress: assert property (@(posedge clock) disable iff (reset)
        !(arValid && awValid))
    else begin
        assertFailures++;
        $error("arValid and awValid high in the same cycle");
    end

endmodule

bind dataCache dataCacheProps props0 (
    .clock       (clock),
    .reset       (reset),
    .cacheDataOk (cacheDataOk),
    .arValid     (arValid),
    .arReady     (arReady),
    .arAddr      (arAddr),
    .awValid     (awValid),
    .awReady     (awReady),
    .awAddr      (awAddr)
);

//--- testbench/dataCacheTb.sv
module dataCacheTb;

    localparam int accessCount = 40;
    localparam int worstMissCycles = 40;
    localparam int clockPeriod = 10;
    // every access a worst-case miss, plus reset and slack
    localparam int watchdogTime = accessCount * worstMissCycles * clockPeriod + 4000;
    localparam int memWords = 512;

    logic clock;
    logic reset;
    logic cacheValid;
    logic cacheOp;
    logic [63:0] cacheAddr;
    logic [63:0] cacheWdata;
    cachePkg::byteMask cacheWmask;
    logic [63:0] cacheData;
    logic cacheDataOk;
    logic arReady;
    logic arValid;
    cachePkg::busAddress arAddr;
    logic [7:0] arLen;
    logic [2:0] arSize;
    logic [1:0] arBurst;
    logic rValid;
    logic rLast;
    logic [63:0] rData;
    logic rReady;
    logic awReady;
    logic awValid;
    cachePkg::busAddress awAddr;
    logic [7:0] awLen;
    logic [2:0] awSize;
    logic [1:0] awBurst;
    logic wReady;
    logic wValid;
    logic wLast;
    logic [63:0] wData;
    logic [7:0] wStrb;
    logic bValid;
    logic bReady;
    logic stallEnable;

    // what the CPU should see at every doubleword
    logic [63:0] refMem [memWords];
    // lines holding a store that memory has not seen yet
    bit storedLine [int];
    int errorCount;
    int testCount;
    int arCount;
    int awCount;
    cachePkg::busAddress lastArAddr;
    cachePkg::busAddress wbLine;
    int wbBeat;

    dataCache dut0 (.*);

    memoryModel mem0 (.*);

    initial begin
        clock = 1'b0;
        forever #(clockPeriod / 2) clock = ~clock;
    end

    function automatic int wordIndex(input logic [63:0] addr);
        return int'(addr[11:3]);
    endfunction

    function automatic cachePkg::busAddress lineAlign(input logic [63:0] addr);
        return {32'd0, addr[31:4], 4'd0};
    endfunction

    task automatic checkData(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
        if (actual !== expected) begin
            errorCount++;
            $display("Error at %0t: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic checkBus(input cachePkg::busAddress actual,
                            input cachePkg::busAddress expected, input string what);
        if (actual !== expected) begin
            errorCount++;
            $display("Error at %0t: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    // burst fields, strobes and last flags
    task automatic checkField(input logic [7:0] actual, input logic [7:0] expected,
                              input string what);
        if (actual !== expected) begin
            errorCount++;
            $display("Error at %0t: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    // byte-mask merge into the expected memory
    task automatic storeRef(input logic [63:0] addr, input logic [63:0] data,
                            input cachePkg::byteMask mask);
        logic [63:0] byteAddr;
        for (int b = 0; b < 8; b++) begin
            if (mask[b]) begin
                byteAddr = addr + 64'(b);
                refMem[wordIndex(byteAddr)][byteAddr[2:0] * 8 +: 8] = data[b * 8 +: 8];
            end
        end
    endtask

    // one CPU request, returns the data and the cycles to cacheDataOk
    task automatic access(input logic write, input logic [63:0] addr,
                          input logic [63:0] data, input cachePkg::byteMask mask,
                          output logic [63:0] rdata, output int cycles);
        cacheValid = 1'b1;
        cacheOp = write;
        cacheAddr = addr;
        cacheWdata = data;
        cacheWmask = mask;
        cycles = 0;
        do begin
            @(posedge clock);
            #1;
            cycles++;
        end while (!cacheDataOk);
        rdata = cacheData;
        // dropped inside the pulse cycle so idle sees no new request
        cacheValid = 1'b0;
        cacheOp = 1'b0;
        @(posedge clock);
        #1;
    endtask

    task automatic readAndCheck(input logic [63:0] addr, input string what);
        logic [63:0] rdata;
        int cycles;
        access(1'b0, addr, '0, '0, rdata, cycles);
        checkData(rdata, refMem[wordIndex(addr)], what);
    endtask

    task automatic writeAndRecord(input logic [63:0] addr, input logic [63:0] data,
                                  input cachePkg::byteMask mask, output int cycles);
        logic [63:0] rdata;
        access(1'b1, addr, data, mask, rdata, cycles);
        storeRef(addr, data, mask);
        storedLine[int'(addr[31:4])] = 1'b1;
    endtask

    // a hit answers in 2 cycles without touching the bus
    task automatic checkHitTiming(input int cycles, input int arBefore, input int awBefore,
                                  input string what);
        if (cycles != 2) begin
            errorCount++;
            $display("Error at %0t: %s took %0d cycles, expected 2", $time, what, cycles);
        end
        if ((arCount != arBefore) || (awCount != awBefore)) begin
            errorCount++;
            $display("%s started a bus burst although it should hit", what);
        end
    endtask

    task automatic finishTest(input string name, input int errorsBefore);
        testCount++;
        if (errorCount == errorsBefore) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errorCount - errorsBefore);
        end
    endtask

    task automatic resetTest();
        int errorsBefore;
        errorsBefore = errorCount;
        if ({cacheDataOk, arValid, awValid, wValid, bReady, rReady} !== 6'b0) begin
            errorCount++;
            $display("Error at %0t: cache outputs active right after reset", $time);
        end
        finishTest("reset", errorsBefore);
    endtask

    task automatic coldReadTest(input int tagBase, input string label);
        logic [63:0] addr;
        logic [63:0] rdata;
        int cycles;
        int errorsBefore;
        int arBefore;
        int awBefore;
        errorsBefore = errorCount;
        // set 1, upper doubleword of the line
        addr = 64'((tagBase << 8) | (1 << 4) | 8);
        arBefore = arCount;
        access(1'b0, addr, '0, '0, rdata, cycles);
        checkData(rdata, refMem[wordIndex(addr)], "cold read data");
        if (arCount != arBefore + 1) begin
            errorCount++;
            $display("cold read made %0d read bursts instead of one", arCount - arBefore);
        end
        checkBus(lastArAddr, lineAlign(addr), "refill address");
        arBefore = arCount;
        awBefore = awCount;
        access(1'b0, addr, '0, '0, rdata, cycles);
        checkData(rdata, refMem[wordIndex(addr)], "repeat read data");
        checkHitTiming(cycles, arBefore, awBefore, "repeat read");
        finishTest({"cold read miss", label}, errorsBefore);
    endtask

    task automatic writeHitTest(input int tagBase, input string label);
        int offsets [4] = '{3, 10, 4, 8};
        int sizes [4] = '{1, 2, 4, 8};
        logic [63:0] lineAddr;
        logic [63:0] wdata;
        cachePkg::byteMask mask;
        int cycles;
        int errorsBefore;
        int arBefore;
        int awBefore;
        errorsBefore = errorCount;
        // same line as the cold read, so every store hits
        lineAddr = 64'((tagBase << 8) | (1 << 4));
        for (int i = 0; i < 4; i++) begin
            // bytes outside the mask are random and must be ignored
            wdata = {$urandom(), $urandom()};
            mask = cachePkg::byteMask'((16'd1 << sizes[i]) - 16'd1);
            arBefore = arCount;
            awBefore = awCount;
            writeAndRecord(lineAddr + 64'(offsets[i]), wdata, mask, cycles);
            checkHitTiming(cycles, arBefore, awBefore, "store hit");
            readAndCheck(lineAddr + 64'(offsets[i] & 8), "readback after store");
        end
        finishTest({"write hits", label}, errorsBefore);
    endtask

    task automatic evictionTest(input int tagBase, input string label);
        logic [63:0] addr [5];
        int cycles;
        int errorsBefore;
        int awBefore;
        errorsBefore = errorCount;
        awBefore = awCount;
        // five tags in set 5 overflow its four ways
        for (int i = 0; i < 5; i++) begin
            addr[i] = 64'(((tagBase + i) << 8) | (5 << 4));
            writeAndRecord(addr[i], {$urandom(), $urandom()}, 8'hff, cycles);
        end
        for (int i = 0; i < 5; i++) begin
            readAndCheck(addr[i], "read after eviction");
        end
        if (awCount == awBefore) begin
            errorCount++;
            $display("five dirty lines in one set caused no writeback");
        end
        finishTest({"dirty eviction", label}, errorsBefore);
    endtask

    task automatic runPhase(input int tagBase, input string label);
        coldReadTest(tagBase, label);
        writeHitTest(tagBase, label);
        evictionTest(tagBase, label);
    endtask

    // bus monitor, sampled at the edge where handshakes complete
    always @(posedge clock) begin
        if (!reset) begin
            if (arValid && arReady) begin
                arCount++;
                lastArAddr = arAddr;
                // two beats of 8 bytes, incrementing
                checkField(arLen, 8'd1, "read burst length");
                checkField({5'd0, arSize}, 8'd3, "read burst size");
                checkField({6'd0, arBurst}, 8'd1, "read burst type");
            end
            if (awValid && awReady) begin
                awCount++;
                wbLine = awAddr;
                wbBeat = 0;
                // victim sits in the set of the pending request
                checkBus(awAddr, {32'd0, awAddr[31:8], cacheAddr[7:4], 4'd0},
                         "writeback address");
                checkField(awLen, 8'd1, "write burst length");
                checkField({5'd0, awSize}, 8'd3, "write burst size");
                checkField({6'd0, awBurst}, 8'd1, "write burst type");
                if (storedLine.exists(int'(awAddr[31:4]))) begin
                    storedLine.delete(int'(awAddr[31:4]));
                end else begin
                    errorCount++;
                    $display("writeback of line %h which holds no store", awAddr);
                end
            end
            // dirty line carries the latest stores, low doubleword first
            if (wValid && wReady) begin
                checkData(wData, refMem[wordIndex(wbLine) + wbBeat], "writeback beat");
                checkField(wStrb, 8'hff, "write strobe");
                // second beat closes the burst
                checkField({7'd0, wLast}, (wbBeat == 1) ? 8'd1 : 8'd0, "write last");
                wbBeat++;
            end
        end
    end

    initial begin
        #(watchdogTime);
        $display("run stopped by the watchdog after %0d time units", watchdogTime);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        void'($urandom(20579));
        errorCount = 0;
        testCount = 0;
        arCount = 0;
        awCount = 0;
        wbBeat = 0;
        // random words mixed with their own byte address
        for (int i = 0; i < memWords; i++) begin
            refMem[i] = {$urandom(), $urandom()} ^ {2{32'(i * 8)}};
            mem0.mem[i] = refMem[i];
        end
        reset = 1'b1;
        cacheValid = 1'b0;
        cacheOp = 1'b0;
        cacheAddr = '0;
        cacheWdata = '0;
        cacheWmask = '0;
        stallEnable = 1'b0;
        repeat (4) @(posedge clock);
        #1;
        reset = 1'b0;
        resetTest();
        runPhase(0, "");
        // fresh tags so the same misses happen again
        stallEnable = 1'b1;
        runPhase(8, " with back-pressure");
        errorCount += dut0.props0.assertFailures;
        $display("%0d tests run, %0d errors", testCount, errorCount);
        if (errorCount == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- dataCache.f
source/cachePkg.sv
source/tagStore.sv
source/lineData.sv
source/cacheController.sv
source/dataCache.sv
testbench/memoryModel.sv
testbench/dataCache_props.sv
testbench/dataCacheTb.sv

//--- Bender.yml
package:
  name: dataCache

sources:
  - files:
      - source/cachePkg.sv
      - source/tagStore.sv
      - source/lineData.sv
      - source/cacheController.sv
      - source/dataCache.sv
  - target: test
    files:
      - testbench/memoryModel.sv
      - testbench/dataCache_props.sv
      - testbench/dataCacheTb.sv
